//--- all.f
hw/memq_pkg.sv
hw/sram32x31.sv
hw/cmd_decode.sv
hw/mem_execute.sv
hw/rsp_result.sv
hw/memq_top.sv
testbench/memq_properties.sv
testbench/memq_tb.sv

//--- hw/cmd_decode.sv
`timescale 1ns/1ns

module cmd_decode (
    input  logic           CK,
    input  logic           rst,
    input  logic           cmd_valid,
    input  memq_pkg::cmd_t cmd,
    output logic           uop_valid,
    output memq_pkg::uop_t uop,
    input  logic           uop_take,
    output logic           cmd_credit
);

    import memq_pkg::*;

    cmd_t                 buf_mem [CMD_CREDITS];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] count;
    cmd_t                 head;

    // ========================================
    // command buffer
    // ========================================

    // the upstream credit count keeps this buffer from overflowing.
    always_ff @(posedge CK) begin
        if (cmd_valid) begin
            buf_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge CK) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (uop_take) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, uop_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a freed slot goes back upstream as one credit.
            cmd_credit <= uop_take;
        end
    end

    assign uop_valid = (count != '0);
    assign head      = buf_mem[rd_ptr];

    // ========================================
    // opcode decode
    // ========================================

    always_comb begin
        uop.op         = head.op;
        uop.addr       = head.addr;
        uop.data       = head.data;
        uop.reads      = 1'b0;
        uop.writes_now = 1'b0;
        uop.wb         = WB_NONE;
        uop.respond    = 1'b0;
        case (head.op)
            OP_READ: begin
                uop.reads   = 1'b1;
                uop.respond = 1'b1;
            end
            OP_WRITE: begin
                uop.writes_now = 1'b1;
            end
            OP_ADD: begin
                uop.reads   = 1'b1;
                uop.respond = 1'b1;
                uop.wb      = WB_SUM;
            end
            OP_SWAP: begin
                uop.reads   = 1'b1;
                uop.respond = 1'b1;
                uop.wb      = WB_OPERAND;
            end
            default: begin
                uop.reads = 1'b0;
            end
        endcase
    end

endmodule

//--- hw/mem_execute.sv
`timescale 1ns/1ns

module mem_execute (
    input  logic                         CK,
    input  logic                         rst,
    input  logic                         uop_valid,
    input  memq_pkg::uop_t               uop,
    output logic                         uop_take,
    input  logic                         rsp_room,
    output logic                         sram_cs,
    output logic                         sram_we,
    output logic [memq_pkg::ADDR_W-1:0]  sram_addr,
    output logic [memq_pkg::DATA_W-1:0]  sram_din,
    input  logic [memq_pkg::DATA_W-1:0]  sram_dout,
    output logic                         rsp_push,
    output memq_pkg::rsp_t               rsp_data
);

    import memq_pkg::*;

    exec_state_e       state;
    uop_t              cur;
    logic [DATA_W-1:0] sum;

    // only one command is in flight, so a write-back always lands before
    // the next access to the same word.
    assign uop_take = (state == EX_IDLE) && uop_valid && rsp_room;

    always_ff @(posedge CK) begin
        if (rst) begin
            state <= EX_IDLE;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (uop_take) begin
                        state <= EX_ACCESS;
                    end
                end
                EX_ACCESS: state <= EX_FINISH;
                EX_FINISH: state <= EX_IDLE;
                default:   state <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge CK) begin
        if (uop_take) begin
            cur <= uop;
        end
    end

    // the carry out of bit 30 is dropped.
    assign sum = sram_dout + cur.data;

    // ========================================
    // SRAM access
    // ========================================

    always_comb begin
        sram_cs   = 1'b0;
        sram_we   = 1'b0;
        sram_addr = cur.addr;
        sram_din  = cur.data;
        case (state)
            EX_ACCESS: begin
                sram_cs = cur.reads || cur.writes_now;
                sram_we = cur.writes_now;
            end
            EX_FINISH: begin
                sram_cs = (cur.wb != WB_NONE);
                sram_we = (cur.wb != WB_NONE);
                if (cur.wb == WB_SUM) begin
                    sram_din = sum;
                end
            end
            default: begin
                sram_cs = 1'b0;
            end
        endcase
    end

    // ========================================
    // response
    // ========================================

    assign rsp_push      = (state == EX_FINISH) && cur.respond;
    assign rsp_data.op   = cur.op;
    assign rsp_data.addr = cur.addr;
    // add answers with the new word, read and swap with the old one.
    assign rsp_data.data = (cur.wb == WB_SUM) ? sum : sram_dout;

endmodule

//--- hw/memq_pkg.sv
package memq_pkg;

    // ========================================
    // sizes and credit depths
    // ========================================

    localparam int ADDR_W      = 5;
    localparam int DATA_W      = 31;
    localparam int DEPTH       = 32;
    localparam int CMD_CREDITS = 4;
    localparam int RSP_CREDITS = 4;
    localparam int RSP_DEPTH   = 4;

    // buffer pointers wrap on their own, so both depths stay powers of two.
    localparam int CMD_PTR_W = $clog2(CMD_CREDITS);
    localparam int CMD_CNT_W = CMD_PTR_W + 1;
    localparam int RSP_PTR_W = $clog2(RSP_DEPTH);
    localparam int RSP_CNT_W = RSP_PTR_W + 1;
    localparam int CRD_W     = $clog2(RSP_CREDITS + 1);

    // ========================================
    // encodings
    // ========================================

    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_ADD   = 2'd2,
        OP_SWAP  = 2'd3
    } op_e;

    typedef enum logic [1:0] {
        EX_IDLE   = 2'd0,
        EX_ACCESS = 2'd1,
        EX_FINISH = 2'd2
    } exec_state_e;

    typedef enum logic [1:0] {
        WB_NONE    = 2'd0,
        WB_OPERAND = 2'd1,
        WB_SUM     = 2'd2
    } wb_e;

    // ========================================
    // payloads
    // ========================================

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } cmd_t;

    // one decoded command, as execute sees it.
    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              reads;
        logic              writes_now;
        wb_e               wb;
        logic              respond;
    } uop_t;

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } rsp_t;

endpackage

//--- hw/memq_top.sv
`timescale 1ns/1ns

module memq_top (
    input  logic           CK,
    input  logic           rst,
    input  logic           cmd_valid,
    input  memq_pkg::cmd_t cmd,
    output logic           cmd_credit,
    output logic           rsp_valid,
    output memq_pkg::rsp_t rsp,
    input  logic           rsp_credit
);

    import memq_pkg::*;

    logic              uop_valid;
    uop_t              uop;
    logic              uop_take;
    logic              rsp_room;
    logic              sram_cs;
    logic              sram_we;
    logic [ADDR_W-1:0] sram_addr;
    logic [DATA_W-1:0] sram_din;
    logic [DATA_W-1:0] sram_dout;
    logic              rsp_push;
    rsp_t              rsp_data;

    cmd_decode u_decode (
        .CK         (CK),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .uop_valid  (uop_valid),
        .uop        (uop),
        .uop_take   (uop_take),
        .cmd_credit (cmd_credit)
    );

    mem_execute u_execute (
        .CK        (CK),
        .rst       (rst),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_take  (uop_take),
        .rsp_room  (rsp_room),
        .sram_cs   (sram_cs),
        .sram_we   (sram_we),
        .sram_addr (sram_addr),
        .sram_din  (sram_din),
        .sram_dout (sram_dout),
        .rsp_push  (rsp_push),
        .rsp_data  (rsp_data)
    );

    rsp_result u_result (
        .CK         (CK),
        .rst        (rst),
        .rsp_push   (rsp_push),
        .rsp_data   (rsp_data),
        .rsp_room   (rsp_room),
        .rsp_credit (rsp_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    sram32x31 u_sram (
        .CK   (CK),
        .cs   (sram_cs),
        .we   (sram_we),
        .addr (sram_addr),
        .din  (sram_din),
        .dout (sram_dout)
    );

endmodule

//--- hw/rsp_result.sv
`timescale 1ns/1ns

module rsp_result (
    input  logic           CK,
    input  logic           rst,
    input  logic           rsp_push,
    input  memq_pkg::rsp_t rsp_data,
    output logic           rsp_room,
    input  logic           rsp_credit,
    output logic           rsp_valid,
    output memq_pkg::rsp_t rsp
);

    import memq_pkg::*;

    rsp_t                 buf_mem [RSP_DEPTH];
    logic [RSP_PTR_W-1:0] wr_ptr;
    logic [RSP_PTR_W-1:0] rd_ptr;
    logic [RSP_CNT_W-1:0] count;
    logic [CRD_W-1:0]     credits;
    logic                 buf_empty;
    logic                 avail;
    logic                 send;
    logic                 do_write;
    logic                 do_pop;
    rsp_t                 head;

    assign buf_empty = (count == '0);

    // an empty buffer passes a new response straight to the output register.
    assign avail    = !buf_empty || rsp_push;
    assign head     = buf_empty ? rsp_data : buf_mem[rd_ptr];
    assign send     = avail && (credits != '0);
    assign do_pop   = send && !buf_empty;
    assign do_write = rsp_push && !(send && buf_empty);

    // Two free slots leave room for the one command inside execute.
    assign rsp_room = (count <= RSP_DEPTH - 2);

    // ========================================
    // response buffer
    // ========================================

    always_ff @(posedge CK) begin
        if (do_write) begin
            buf_mem[wr_ptr] <= rsp_data;
        end
    end

    always_ff @(posedge CK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ========================================
    // outgoing credits and output register
    // ========================================

    always_ff @(posedge CK) begin
        if (rst) begin
            credits   <= CRD_W'(RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            case ({rsp_credit, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            rsp_valid <= send;
        end
    end

    always_ff @(posedge CK) begin
        if (send) begin
            rsp <= head;
        end
    end

endmodule

//--- hw/sram32x31.sv
`timescale 1ns/1ns

module sram32x31 (
    input  logic                          CK,
    input  logic                          cs,
    input  logic                          we,
    input  logic [memq_pkg::ADDR_W-1:0]   addr,
    input  logic [memq_pkg::DATA_W-1:0]   din,
    output logic [memq_pkg::DATA_W-1:0]   dout
);

    import memq_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] rd_word;

    // an unselected array gives nothing useful on its output.
    assign rd_word = cs ? mem[addr] : 'x;

    always_ff @(posedge CK) begin
        if (cs && we) begin
            mem[addr] <= din;
        end
    end

    // the read port is registered, so data shows up one cycle after the access.
    always_ff @(posedge CK) begin
        dout <= rd_word;
    end

endmodule

//--- testbench/memq_properties.sv
`timescale 1ns/1ns

module memq_properties (
    input logic           CK,
    input logic           rst,
    input logic           cmd_valid,
    input logic           cmd_credit,
    input logic           rsp_valid,
    input memq_pkg::rsp_t rsp,
    input logic           rsp_credit
);

    import memq_pkg::*;

    int outstanding;
    int up_credits;

    // responses in flight downstream and credits still held by the upstream agent.
    always @(posedge CK) begin
        if (rst) begin
            outstanding <= 0;
            up_credits  <= CMD_CREDITS;
        end else begin
            outstanding <= outstanding + int'(rsp_valid) - int'(rsp_credit);
            up_credits  <= up_credits - int'(cmd_valid) + int'(cmd_credit);
        end
    end

    quiet_after_reset: assert property (@(posedge CK) $past(rst) |-> !cmd_credit && !rsp_valid)
        else $error("cmd_credit or rsp_valid high right after reset");

    rsp_credit_limit: assert property (@(posedge CK) disable iff (rst)
        (outstanding + int'(rsp_valid)) <= RSP_CREDITS)
        else $error("more responses outstanding than response credits");

    cmd_credit_held: assert property (@(posedge CK) disable iff (rst)
        cmd_valid |-> up_credits > 0)
        else $error("command sent without a command credit");

    rsp_known: assert property (@(posedge CK) disable iff (rst) rsp_valid |-> !$isunknown(rsp))
        else $error("response fields unknown while rsp_valid is high");

endmodule

bind memq_top memq_properties u_properties (.*);

//--- testbench/memq_tb.sv
`timescale 1ns/1ns

module memq_tb;

    import memq_pkg::*;

    localparam int N_RANDOM       = 200;
    localparam int N_BURST        = 16;
    localparam int N_HOLD         = 36;
    localparam int NUM_CMDS       = 2 * DEPTH + N_RANDOM + N_BURST + N_HOLD;
    localparam int TIMEOUT_FACTOR = 40;

    logic CK;
    logic rst;
    logic cmd_valid;
    cmd_t cmd;
    logic cmd_credit;
    logic rsp_valid;
    rsp_t rsp;
    logic rsp_credit;

    integer            seed;
    logic [DATA_W-1:0] mem_model [int];
    rsp_t              exp_q [$];
    int credits_held;
    int pending;
    int hold_cycles;
    int cycles;
    int cmds_sent;
    int exp_rsp_total;
    int rsp_count;
    int credit_pulses;
    int credits_returned;

    memq_top u_memq_top (
        .CK         (CK),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    initial begin
        CK = 1'b0;
        forever begin
            #2 CK = ~CK;
        end
    end

    // ========================================
    // checks
    // ========================================

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input rsp_t got, input rsp_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t ns: rsp expected %h/%h/%h, got %h/%h/%h",
                $time, exp.op, exp.addr, exp.data, got.op, got.addr, got.data));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            stop_on_error($sformatf("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
                $time, name, exp, got));
        end
    endtask

    // outputs settle well before the falling edge.
    always @(negedge CK) begin
        cycles++;
        if (cycles >= TIMEOUT_FACTOR * NUM_CMDS) begin
            stop_on_error($sformatf("timeout after %0d cycles with %0d responses still expected",
                cycles, exp_q.size()));
        end
        if (!rst) begin
            if (cmd_credit) begin
                credits_held++;
                credit_pulses++;
            end
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("a response arrived with no command outstanding");
                end else begin
                    check_rsp(rsp, exp_q.pop_front());
                end
                rsp_count++;
                pending++;
                if (rsp_count - credits_returned > RSP_CREDITS) begin
                    stop_on_error("the engine sent more responses than its credits allow");
                end
            end
            if (rsp_credit) begin
                credits_returned++;
            end
        end
    end

    // ========================================
    // stimulus
    // ========================================

    // the downstream side frees responses at random unless a hold is running.
    task automatic step();
        @(posedge CK);
        #1;
        cmd_valid  = 1'b0;
        rsp_credit = 1'b0;
        if (hold_cycles > 0) begin
            hold_cycles--;
        end else if (pending > 0 && ($random(seed) & 1)) begin
            rsp_credit = 1'b1;
            pending--;
        end
    endtask

    task automatic send_cmd(input op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data);
        rsp_t              exp;
        logic [DATA_W-1:0] old;
        while (credits_held == 0) begin
            step();
        end
        old = '0;
        if (mem_model.exists(int'(addr))) begin
            old = mem_model[int'(addr)];
        end
        exp.op   = op;
        exp.addr = addr;
        exp.data = old;
        case (op)
            OP_WRITE: mem_model[int'(addr)] = data;
            OP_SWAP:  mem_model[int'(addr)] = data;
            OP_ADD: begin
                exp.data = old + data;
                mem_model[int'(addr)] = exp.data;
            end
            default: exp.data = old;
        endcase
        if (op != OP_WRITE) begin
            exp_q.push_back(exp);
            exp_rsp_total++;
        end
        cmd_valid = 1'b1;
        cmd.op    = op;
        cmd.addr  = addr;
        cmd.data  = data;
        credits_held--;
        cmds_sent++;
        step();
    endtask

    task automatic send_random();
        send_cmd(op_e'($random(seed) & 3), ADDR_W'($random(seed)), DATA_W'($random(seed)));
    endtask

    initial begin
        logic [ADDR_W-1:0] hot_addr;
        seed         = 32'he782_8939;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        rsp_credit   = 1'b0;
        credits_held = CMD_CREDITS;
        repeat (8) @(posedge CK);
        #1;
        rst = 1'b0;

        for (int a = 0; a < DEPTH; a++) begin
            send_cmd(OP_WRITE, ADDR_W'(a), DATA_W'($random(seed)));
        end
        for (int a = 0; a < DEPTH; a++) begin
            send_cmd(OP_READ, ADDR_W'(a), '0);
        end
        repeat (N_RANDOM) send_random();

        hot_addr = ADDR_W'($random(seed));
        for (int i = 0; i < N_BURST; i++) begin
            send_cmd((i % 2) ? OP_SWAP : OP_ADD, hot_addr, DATA_W'($random(seed)));
        end

        // long stalls on the response side fill the result buffer.
        repeat (3) begin
            hold_cycles = 40;
            repeat (N_HOLD / 3) send_random();
        end

        hold_cycles = 0;
        while (exp_q.size() != 0) begin
            step();
        end
        // at most CMD_CREDITS writes can still wait in decode, three cycles each.
        repeat (3 * CMD_CREDITS + 2) begin
            step();
        end
        check_count(rsp_count, exp_rsp_total, "rsp_valid count");
        check_count(credit_pulses, cmds_sent, "cmd_credit count");
        $display("Simulation PASSED");
        $finish;
    end

endmodule
